//--- hw/snd_pkg.sv
// Stereo up-rate shared definitions
package snd_pkg;

    // Audio sample width, one channel
    localparam int SAMPLE_W = 16;

    // Coefficients are signed Q1.14
    localparam int COEF_W    = 16;
    localparam int COEF_FRAC = 14;

    // Taps in each polyphase branch
    localparam int HALF_TAPS = 4;

    // Accumulator with headroom for four full-scale products
    localparam int ACC_W = 36;

    // Half-sample phase, tap 0 is the newest sample
    localparam logic signed [COEF_W-1:0] INTERP_COEF [HALF_TAPS] = '{
        -16'sd2048,
        16'sd10240,
        16'sd10240,
        -16'sd2048
    };

    // On-sample phase, passes the previous sample at unity gain
    localparam logic signed [COEF_W-1:0] DIRECT_COEF [HALF_TAPS] = '{
        16'sd0,
        16'sd16384,
        16'sd0,
        16'sd0
    };

    // Two phases, one gap cycle and margin for the output stage
    localparam int IN_GAP_MIN = 2 * HALF_TAPS + 4;

    // One stereo sample, seen as a whole word or split by channel
    typedef union packed {
        logic [2*SAMPLE_W-1:0] raw;
        struct packed {
            logic signed [SAMPLE_W-1:0] l;
            logic signed [SAMPLE_W-1:0] r;
        } ch;
    } stereo_word_t;

endpackage

//--- hw/snd_hist_buf.sv
// Stereo sample history
`timescale 1ns/1ps

module snd_hist_buf import snd_pkg::*; (
    input  logic                       snd_sample,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic signed [SAMPLE_W-1:0] in_l,
    input  logic signed [SAMPLE_W-1:0] in_r,
    input  logic [1:0]                 tap_sel,
    output stereo_word_t               tap_word
);

    stereo_word_t          in_word;
    logic [2*SAMPLE_W-1:0] hist_raw [HALF_TAPS];

    // Left in the upper half, right in the lower half
    assign in_word.raw = {in_l, in_r};

    // Shift on every input strobe, bypass mode included
    always_ff @(posedge snd_sample) begin
        if (!rst_n) begin
            for (int i = 0; i < HALF_TAPS; i++) begin
                hist_raw[i] <= '0;
            end
        end else if (in_valid) begin
            hist_raw[0] <= in_word.raw;
            for (int i = 1; i < HALF_TAPS; i++) begin
                hist_raw[i] <= hist_raw[i-1];
            end
        end
    end

    // Tap 0 is the newest sample
    assign tap_word.raw = hist_raw[tap_sel];

    // The sequencer must always point at a real tap
    a_tap_sel_known: assert property (
        @(posedge snd_sample) rst_n |-> !$isunknown(tap_sel)
    ) else $error("snd_hist_buf: tap_sel unknown");

endmodule

//--- hw/snd_phase_ctrl.sv
// Polyphase tap sequencer
`timescale 1ns/1ps

module snd_phase_ctrl import snd_pkg::*; (
    input  logic       snd_sample,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic [1:0] tap_sel,
    output logic       phase,
    output logic       mac_en,
    output logic       mac_first,
    output logic       mac_last
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_PH0  = 2'd1;
    localparam logic [1:0] ST_GAP  = 2'd2;
    localparam logic [1:0] ST_PH1  = 2'd3;

    localparam logic [1:0] LAST_TAP = 2'(HALF_TAPS - 1);

    logic [1:0] state;
    logic [1:0] tap_cnt;

    always_ff @(posedge snd_sample) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            tap_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    tap_cnt <= '0;
                    if (in_valid) begin
                        state <= ST_PH0;
                    end
                end
                ST_PH0: begin
                    tap_cnt <= tap_cnt + 2'd1;
                    if (tap_cnt == LAST_TAP) begin
                        state   <= ST_GAP;
                        tap_cnt <= '0;
                    end
                end
                // One spare cycle so the first result drains
                ST_GAP: begin
                    state <= ST_PH1;
                end
                default: begin
                    tap_cnt <= tap_cnt + 2'd1;
                    if (tap_cnt == LAST_TAP) begin
                        state   <= ST_IDLE;
                        tap_cnt <= '0;
                    end
                end
            endcase
        end
    end

    // Phase 0 interpolates, phase 1 is the direct sample
    assign phase     = (state == ST_PH1);
    assign mac_en    = (state == ST_PH0) || (state == ST_PH1);
    assign mac_first = mac_en && (tap_cnt == '0);
    assign mac_last  = mac_en && (tap_cnt == LAST_TAP);
    assign tap_sel   = tap_cnt;

    // No back-pressure, a new sample while busy would be lost
    a_no_input_busy: assert property (
        @(posedge snd_sample) disable iff (!rst_n)
        in_valid |-> state == ST_IDLE
    ) else $error("snd_phase_ctrl: input strobe while sequencer busy");

endmodule

//--- hw/snd_fir_mac.sv
// Stereo FIR multiply-accumulate
`timescale 1ns/1ps

module snd_fir_mac import snd_pkg::*; (
    input  logic                       snd_sample,
    input  logic                       rst_n,
    input  stereo_word_t               tap_word,
    input  logic                       phase,
    input  logic                       mac_en,
    input  logic                       mac_first,
    input  logic                       mac_last,
    output logic                       res_valid,
    output logic signed [SAMPLE_W-1:0] res_l,
    output logic signed [SAMPLE_W-1:0] res_r
);

    localparam logic signed [ACC_W-1:0] ROUND_HALF = ACC_W'(1 << (COEF_FRAC - 1));
    localparam logic signed [ACC_W-1:0] SAT_HI     = ACC_W'((1 << (SAMPLE_W - 1)) - 1);
    localparam logic signed [ACC_W-1:0] SAT_LO     = -SAT_HI - ACC_W'(1);

    localparam logic [1:0] LAST_TAP = 2'(HALF_TAPS - 1);

    logic [1:0]                 tap_cnt;
    logic [1:0]                 cur_tap;
    logic signed [COEF_W-1:0]   coef;
    logic signed [2*COEF_W-1:0] mul_l;
    logic signed [2*COEF_W-1:0] mul_r;
    logic signed [ACC_W-1:0]    prod_l;
    logic signed [ACC_W-1:0]    prod_r;
    logic signed [ACC_W-1:0]    acc_l;
    logic signed [ACC_W-1:0]    acc_r;
    logic signed [ACC_W-1:0]    acc_next_l;
    logic signed [ACC_W-1:0]    acc_next_r;

    // Round to nearest, drop fraction bits, clamp to 16 bits
    function automatic logic signed [SAMPLE_W-1:0] round_sat(
        input logic signed [ACC_W-1:0] acc
    );
        logic signed [ACC_W-1:0] shf;
        shf = (acc + ROUND_HALF) >>> COEF_FRAC;
        if (shf > SAT_HI) begin
            return SAT_HI[SAMPLE_W-1:0];
        end else if (shf < SAT_LO) begin
            return SAT_LO[SAMPLE_W-1:0];
        end
        return shf[SAMPLE_W-1:0];
    endfunction

    // Local tap index follows the sequencer, restarting on mac_first
    always_ff @(posedge snd_sample) begin
        if (!rst_n) begin
            tap_cnt <= '0;
        end else if (mac_en) begin
            tap_cnt <= cur_tap + 2'd1;
        end
    end

    assign cur_tap = mac_first ? 2'd0 : tap_cnt;
    assign coef    = phase ? DIRECT_COEF[cur_tap] : INTERP_COEF[cur_tap];

    assign mul_l  = $signed(tap_word.ch.l) * coef;
    assign mul_r  = $signed(tap_word.ch.r) * coef;
    assign prod_l = ACC_W'(mul_l);
    assign prod_r = ACC_W'(mul_r);

    // First tap reloads instead of adding
    assign acc_next_l = (mac_first ? '0 : acc_l) + prod_l;
    assign acc_next_r = (mac_first ? '0 : acc_r) + prod_r;

    always_ff @(posedge snd_sample) begin
        if (mac_en) begin
            acc_l <= acc_next_l;
            acc_r <= acc_next_r;
        end
    end

    // Result lands the cycle after the last tap
    always_ff @(posedge snd_sample) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            res_l     <= '0;
            res_r     <= '0;
        end else begin
            res_valid <= mac_last;
            if (mac_last) begin
                res_l <= round_sat(acc_next_l);
                res_r <= round_sat(acc_next_r);
            end
        end
    end

    // Local tap index must agree with the sequencer's last tap
    a_last_in_run: assert property (
        @(posedge snd_sample) disable iff (!rst_n)
        mac_last |-> mac_en && cur_tap == LAST_TAP
    ) else $error("snd_fir_mac: mac_last outside an accumulate run or off the last tap");

endmodule

//--- hw/snd_out_stage.sv
// Output register and bypass select
`timescale 1ns/1ps

module snd_out_stage import snd_pkg::*; (
    input  logic                       snd_sample,
    input  logic                       rst_n,
    input  logic                       enable_interp,
    input  logic                       in_valid,
    input  logic signed [SAMPLE_W-1:0] in_l,
    input  logic signed [SAMPLE_W-1:0] in_r,
    input  logic                       res_valid,
    input  logic signed [SAMPLE_W-1:0] res_l,
    input  logic signed [SAMPLE_W-1:0] res_r,
    output logic                       out_valid,
    output logic signed [SAMPLE_W-1:0] out_l,
    output logic signed [SAMPLE_W-1:0] out_r
);

    stereo_word_t sel_word;
    logic         sel_valid;

    // Pick the source pair as one word, then split it back
    assign sel_word.raw = enable_interp ? {res_l, res_r} : {in_l, in_r};
    assign sel_valid    = enable_interp ? res_valid : in_valid;

    always_ff @(posedge snd_sample) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_l     <= '0;
            out_r     <= '0;
        end else begin
            out_valid <= sel_valid;
            // Hold the last pair between strobes
            if (sel_valid) begin
                out_l <= sel_word.ch.l;
                out_r <= sel_word.ch.r;
            end
        end
    end

    // Results are HALF_TAPS+1 apart and inputs IN_GAP_MIN apart
    a_single_strobe: assert property (
        @(posedge snd_sample) disable iff (!rst_n)
        out_valid |=> !out_valid
    ) else $error("snd_out_stage: out_valid high on consecutive cycles");

endmodule

//--- hw/snd_uprate2_top.sv
// Stereo 2x up-rate interpolator
`timescale 1ns/1ps

module snd_uprate2_top import snd_pkg::*; (
    input  logic                       snd_sample,
    input  logic                       rst_n,
    input  logic                       enable_interp,
    input  logic                       in_valid,
    input  logic signed [SAMPLE_W-1:0] in_l,
    input  logic signed [SAMPLE_W-1:0] in_r,
    output logic                       out_valid,
    output logic signed [SAMPLE_W-1:0] out_l,
    output logic signed [SAMPLE_W-1:0] out_r
);

    logic [1:0]                 tap_sel;
    stereo_word_t               tap_word;
    logic                       phase;
    logic                       mac_en;
    logic                       mac_first;
    logic                       mac_last;
    logic                       res_valid;
    logic signed [SAMPLE_W-1:0] res_l;
    logic signed [SAMPLE_W-1:0] res_r;

    snd_hist_buf u_hist (
        .snd_sample ( snd_sample ),
        .rst_n      ( rst_n      ),
        .in_valid   ( in_valid   ),
        .in_l       ( in_l       ),
        .in_r       ( in_r       ),
        .tap_sel    ( tap_sel    ),
        .tap_word   ( tap_word   )
    );

    snd_phase_ctrl u_ctrl (
        .snd_sample ( snd_sample ),
        .rst_n      ( rst_n      ),
        .in_valid   ( in_valid   ),
        .tap_sel    ( tap_sel    ),
        .phase      ( phase      ),
        .mac_en     ( mac_en     ),
        .mac_first  ( mac_first  ),
        .mac_last   ( mac_last   )
    );

    snd_fir_mac u_mac (
        .snd_sample ( snd_sample ),
        .rst_n      ( rst_n      ),
        .tap_word   ( tap_word   ),
        .phase      ( phase      ),
        .mac_en     ( mac_en     ),
        .mac_first  ( mac_first  ),
        .mac_last   ( mac_last   ),
        .res_valid  ( res_valid  ),
        .res_l      ( res_l      ),
        .res_r      ( res_r      )
    );

    snd_out_stage u_out (
        .snd_sample    ( snd_sample    ),
        .rst_n         ( rst_n         ),
        .enable_interp ( enable_interp ),
        .in_valid      ( in_valid      ),
        .in_l          ( in_l          ),
        .in_r          ( in_r          ),
        .res_valid     ( res_valid     ),
        .res_l         ( res_l         ),
        .res_r         ( res_r         ),
        .out_valid     ( out_valid     ),
        .out_l         ( out_l         ),
        .out_r         ( out_r         )
    );

endmodule

//--- bench/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic snd_sample,
    output logic rst_n
);

    initial begin
        snd_sample = 1'b0;
        forever #(PERIOD / 2) snd_sample = ~snd_sample;
    end

    // Reset released on a rising edge, like any other driven input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge snd_sample);
        rst_n <= 1'b1;
    end

endmodule

//--- bench/tb_snd_uprate2.sv
// Up-rate interpolator testbench
`timescale 1ns/1ps

module tb_snd_uprate2 import snd_pkg::*; ();

    // 8 bypass, 24 random, 8 full-scale, 3 + 4 for the mode switch
    localparam int N_INPUTS  = 47;
    localparam int CYC_LIMIT = (N_INPUTS + 10) * IN_GAP_MIN;
    localparam int EXP_DEPTH = 256;

    logic                       snd_sample;
    logic                       rst_n;
    logic                       enable_interp;
    logic                       in_valid;
    logic signed [SAMPLE_W-1:0] in_l;
    logic signed [SAMPLE_W-1:0] in_r;
    logic                       out_valid;
    logic signed [SAMPLE_W-1:0] out_l;
    logic signed [SAMPLE_W-1:0] out_r;

    int seed    = 32'h4a51c77f;
    int test_id = 0;
    int cyc_cnt = 0;

    // Expected outputs, oldest at exp_rd
    logic signed [SAMPLE_W-1:0] exp_l_mem   [EXP_DEPTH];
    logic signed [SAMPLE_W-1:0] exp_r_mem   [EXP_DEPTH];
    int                         exp_tid_mem [EXP_DEPTH];
    logic [7:0]                 exp_wr    = '0;
    logic [7:0]                 exp_rd    = '0;
    logic                       any_input = 1'b0;
    logic signed [SAMPLE_W-1:0] head_l;
    logic signed [SAMPLE_W-1:0] head_r;
    int                         head_tid;

    // Model history, index 0 newest
    int hist_l [HALF_TAPS];
    int hist_r [HALF_TAPS];

    int mis_l_cnt   = 0;
    int mis_r_cnt   = 0;
    int extra_cnt   = 0;
    int missing_cnt = 0;
    int idle_cnt    = 0;
    int drain_cnt   = 0;

    tb_clock_gen #(
        .PERIOD       ( 8 ),
        .RESET_CYCLES ( 3 )
    ) clk_gen_i (
        .snd_sample ( snd_sample ),
        .rst_n      ( rst_n      )
    );

    snd_uprate2_top dut_i (
        .snd_sample    ( snd_sample    ),
        .rst_n         ( rst_n         ),
        .enable_interp ( enable_interp ),
        .in_valid      ( in_valid      ),
        .in_l          ( in_l          ),
        .in_r          ( in_r          ),
        .out_valid     ( out_valid     ),
        .out_l         ( out_l         ),
        .out_r         ( out_r         )
    );

    function automatic string test_label(input int id);
        case (id)
            1:       return "bypass";
            2:       return "interp_random";
            3:       return "saturation";
            4:       return "mode_switch";
            default: return "reset_idle";
        endcase
    endfunction

    // Half-sample phase over s0 (newest) to s3, Q1.14 with round and clamp
    function automatic logic signed [SAMPLE_W-1:0] interp_expect(
        input int s0,
        input int s1,
        input int s2,
        input int s3
    );
        int acc;
        int q;
        acc = int'(INTERP_COEF[0]) * s0 + int'(INTERP_COEF[1]) * s1
            + int'(INTERP_COEF[2]) * s2 + int'(INTERP_COEF[3]) * s3;
        q = (acc + (1 << (COEF_FRAC - 1))) >>> COEF_FRAC;
        if (q > 32767) begin
            q = 32767;
        end else if (q < -32768) begin
            q = -32768;
        end
        return SAMPLE_W'(q);
    endfunction

    // Reference model follows the sampled input strobe
    always @(posedge snd_sample) begin
        if (!rst_n) begin
            exp_wr    <= '0;
            exp_rd    <= '0;
            any_input <= 1'b0;
            hist_l    = '{0, 0, 0, 0};
            hist_r    = '{0, 0, 0, 0};
        end else begin
            if (out_valid) begin
                exp_rd <= exp_rd + 8'd1;
            end
            if (in_valid) begin
                any_input <= 1'b1;
                // History moves in bypass too
                hist_l[3] = hist_l[2];
                hist_l[2] = hist_l[1];
                hist_l[1] = hist_l[0];
                hist_l[0] = int'(in_l);
                hist_r[3] = hist_r[2];
                hist_r[2] = hist_r[1];
                hist_r[1] = hist_r[0];
                hist_r[0] = int'(in_r);
                if (enable_interp) begin
                    exp_l_mem[exp_wr]          <= interp_expect(hist_l[0], hist_l[1],
                                                                hist_l[2], hist_l[3]);
                    exp_r_mem[exp_wr]          <= interp_expect(hist_r[0], hist_r[1],
                                                                hist_r[2], hist_r[3]);
                    exp_tid_mem[exp_wr]        <= test_id;
                    // Direct phase is the previous input
                    exp_l_mem[exp_wr + 8'd1]   <= SAMPLE_W'(hist_l[1]);
                    exp_r_mem[exp_wr + 8'd1]   <= SAMPLE_W'(hist_r[1]);
                    exp_tid_mem[exp_wr + 8'd1] <= test_id;
                    exp_wr                     <= exp_wr + 8'd2;
                end else begin
                    exp_l_mem[exp_wr]   <= in_l;
                    exp_r_mem[exp_wr]   <= in_r;
                    exp_tid_mem[exp_wr] <= test_id;
                    exp_wr              <= exp_wr + 8'd1;
                end
            end
        end
    end

    assign head_l   = exp_l_mem[exp_rd];
    assign head_r   = exp_r_mem[exp_rd];
    assign head_tid = exp_tid_mem[exp_rd];

    a_idle_quiet: assert property (
        @(posedge snd_sample) (cyc_cnt > 0 && !any_input) |->
            (!out_valid && out_l == '0 && out_r == '0)
    ) else begin
        idle_cnt = idle_cnt + 1;
        $display("Outputs active before any input at %0t: valid=%0b l=%0d r=%0d",
                 $time, $sampled(out_valid), $sampled(out_l), $sampled(out_r));
    end

    a_no_extra: assert property (
        @(posedge snd_sample) disable iff (!rst_n) out_valid |-> exp_rd != exp_wr
    ) else begin
        extra_cnt = extra_cnt + 1;
        $display("Extra out_valid strobe at %0t with no output expected", $time);
    end

    a_left: assert property (
        @(posedge snd_sample) disable iff (!rst_n)
        (out_valid && exp_rd != exp_wr) |-> out_l == head_l
    ) else begin
        mis_l_cnt = mis_l_cnt + 1;
        $display("Mismatch %s out_l: expected %0d, actual %0d",
                 test_label($sampled(head_tid)), $sampled(head_l), $sampled(out_l));
    end

    a_right: assert property (
        @(posedge snd_sample) disable iff (!rst_n)
        (out_valid && exp_rd != exp_wr) |-> out_r == head_r
    ) else begin
        mis_r_cnt = mis_r_cnt + 1;
        $display("Mismatch %s out_r: expected %0d, actual %0d",
                 test_label($sampled(head_tid)), $sampled(head_r), $sampled(out_r));
    end

    // All strobes of one input must be out before the next input
    a_drained: assert property (
        @(posedge snd_sample) disable iff (!rst_n) in_valid |-> exp_rd == exp_wr
    ) else begin
        missing_cnt = missing_cnt + 1;
        $display("Missing out_valid strobe, %0d outputs still pending at %0t",
                 $sampled(exp_wr) - $sampled(exp_rd), $time);
    end

    always @(posedge snd_sample) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= CYC_LIMIT) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cyc_cnt);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic send_sample(
        input logic signed [SAMPLE_W-1:0] l,
        input logic signed [SAMPLE_W-1:0] r
    );
        @(posedge snd_sample);
        in_valid <= 1'b1;
        in_l     <= l;
        in_r     <= r;
        @(posedge snd_sample);
        in_valid <= 1'b0;
        repeat (IN_GAP_MIN - 2) @(posedge snd_sample);
    endtask

    // One spare cycle so the last result has left the output stage
    task automatic set_mode(input logic interp);
        @(posedge snd_sample);
        enable_interp <= interp;
    endtask

    task automatic send_random(input int count);
        logic [31:0] rnd;
        for (int n = 0; n < count; n++) begin
            rnd = $random(seed);
            send_sample(rnd[31:16], rnd[15:0]);
        end
    endtask

    initial begin
        logic signed [SAMPLE_W-1:0] sat_l;
        logic signed [SAMPLE_W-1:0] sat_r;
        int                         total;
        enable_interp = 1'b0;
        in_valid      = 1'b0;
        in_l          = '0;
        in_r          = '0;

        while (rst_n !== 1'b1) @(posedge snd_sample);
        repeat (IN_GAP_MIN) @(posedge snd_sample);

        test_id = 1;
        send_random(8);

        set_mode(1'b1);
        test_id = 2;
        send_random(24);

        // Full-scale pairs, right channel mirrored
        test_id = 3;
        for (int n = 0; n < 8; n++) begin
            if (n[1] == 1'b0) begin
                sat_l = 16'sh7fff;
                sat_r = 16'sh8000;
            end else begin
                sat_l = 16'sh8000;
                sat_r = 16'sh7fff;
            end
            send_sample(sat_l, sat_r);
        end

        test_id = 4;
        set_mode(1'b0);
        send_random(3);
        set_mode(1'b1);
        send_random(4);

        repeat (IN_GAP_MIN) @(posedge snd_sample);
        a_all_seen: assert (exp_rd == exp_wr) else begin
            drain_cnt = drain_cnt + 1;
            $display("Run ended with %0d expected outputs never seen", exp_wr - exp_rd);
        end

        total = mis_l_cnt + mis_r_cnt + extra_cnt + missing_cnt + idle_cnt + drain_cnt;
        $display("Errors: left=%0d right=%0d extra=%0d missing=%0d idle=%0d drain=%0d",
                 mis_l_cnt, mis_r_cnt, extra_cnt, missing_cnt, idle_cnt, drain_cnt);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/snd_pkg.sv
hw/snd_hist_buf.sv
hw/snd_phase_ctrl.sv
hw/snd_fir_mac.sv
hw/snd_out_stage.sv
hw/snd_uprate2_top.sv
bench/tb_clock_gen.sv
bench/tb_snd_uprate2.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the up-rate interpolator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_snd_uprate2 \
    --Mdir obj_dir \
    -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_snd_uprate2)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
